// ==== compile.f ====
+incdir+verilog
verilog/matmul_pkg.sv
verilog/matmul_ctrl.sv
verilog/matmul_addr_gen.sv
verilog/matmul_mac.sv
verilog/matmul_result_writer.sv
verilog/matmul_top.sv
verification/matmul_sva.sv
verification/tb_matmul.sv

// ==== Bender.yml ====
package:
  name: matmul

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/matmul_pkg.sv
      - verilog/matmul_ctrl.sv
      - verilog/matmul_addr_gen.sv
      - verilog/matmul_mac.sv
      - verilog/matmul_result_writer.sv
      - verilog/matmul_top.sv
  - target: simulation
    files:
      - verification/matmul_sva.sv
      - verification/tb_matmul.sv

// ==== verification/tb_matmul.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_matmul
  import matmul_pkg::*;
();

  // Longest run is 4x4x4, about 100 cycles
  localparam int run_timeout = 400;
  localparam int fill_depth  = 32;

  logic     clk;
  logic     reset_n;
  logic     dut_valid;
  logic     dut_ready;
  addr_t    input_rd_addr;
  addr_t    weight_rd_addr;
  data_t    input_rd_data;
  data_t    weight_rd_data;
  sram_wr_t result_wr;

  data_t  input_mem   [0:65535];
  data_t  weight_mem  [0:65535];
  data_t  result_mem  [0:65535];
  int     write_count [0:65535];
  int     total_writes;
  data_t  a_mat [4][4];
  data_t  b_mat [4][4];
  integer seed;
  int     errors;
  int     tests_run;
  int     tests_failed;
  bit     timed_out;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  matmul_top u_matmul_top (
    .clk            (clk),
    .reset_n        (reset_n),
    .dut_valid      (dut_valid),
    .dut_ready      (dut_ready),
    .input_rd_addr  (input_rd_addr),
    .input_rd_data  (input_rd_data),
    .weight_rd_addr (weight_rd_addr),
    .weight_rd_data (weight_rd_data),
    .result_wr      (result_wr)
  );

  bind matmul_top matmul_sva u_sva (
    .clk       (clk),
    .reset_n   (reset_n),
    .dut_valid (dut_valid),
    .dut_ready (dut_ready),
    .result_wr (result_wr)
  );

  // Input and weight SRAMs, data one cycle after the address
  always @(posedge clk) begin
    input_rd_data  <= input_mem[input_rd_addr];
    weight_rd_data <= weight_mem[weight_rd_addr];
  end

  always @(posedge clk) begin
    if (result_wr.we) begin
      result_mem[result_wr.addr]  <= result_wr.data;
      write_count[result_wr.addr] <= write_count[result_wr.addr] + 1;
      total_writes                <= total_writes + 1;
    end
  end

  function automatic data_t pick_value(input bit extreme);
    data_t r;
    r = $random(seed);
    if (!extreme) begin
      return r;
    end
    // Just below +2^31 or just above -2^31
    return r[31] ? 32'h7fff_fff8 + r[2:0] : 32'h8000_0000 + r[2:0];
  endfunction

  // C(row, col) straight from the definition, wrapping at 32 bits
  function automatic data_t golden_element(input int row, input int col, input int depth);
    data_t sum;
    sum = '0;
    for (int i = 0; i < depth; i++) begin
      sum = sum + a_mat[row][i] * b_mat[i][col];
    end
    return sum;
  endfunction

  task automatic fill_matrices(input int m, input int k, input int n, input bit extreme);
    for (int i = 0; i < fill_depth; i++) begin
      input_mem[i]  = $random(seed);
      weight_mem[i] = $random(seed);
      write_count[i] = 0;
    end
    total_writes  = 0;
    input_mem[0]  = {m[15:0], k[15:0]};
    weight_mem[0] = {k[15:0], n[15:0]};
    for (int r = 0; r < m; r++) begin
      for (int c = 0; c < k; c++) begin
        a_mat[r][c] = pick_value(extreme);
        input_mem[1 + r * k + c] = a_mat[r][c];
      end
    end
    // B goes in column by column
    for (int r = 0; r < k; r++) begin
      for (int c = 0; c < n; c++) begin
        b_mat[r][c] = pick_value(extreme);
        weight_mem[1 + c * k + r] = b_mat[r][c];
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic run_case(input string name, input int m, input int k, input int n,
                          input bit hold_valid, input bit extreme);
    int    cycles;
    int    pulses;
    int    errs_before;
    bit    done;
    data_t expected;
    if (timed_out) begin
      return;
    end
    errs_before = errors;
    fill_matrices(m, k, n, extreme);
    @(posedge clk);
    dut_valid <= 1'b1;
    // Accepting edge, the DUT is idle here
    @(posedge clk);
    if (!hold_valid) begin
      dut_valid <= 1'b0;
    end
    cycles = 0;
    pulses = 0;
    done   = 1'b0;
    while (!done && cycles < run_timeout) begin
      @(negedge clk);
      cycles++;
      if (dut_ready) begin
        done = 1'b1;
      end else if (result_wr.we) begin
        pulses++;
        // Drop a held request before ready comes back
        if (hold_valid && pulses == m * n) begin
          @(posedge clk);
          dut_valid <= 1'b0;
        end
      end
    end
    if (!done) begin
      $display("Timeout: dut_ready never came back during %s", name);
      timed_out = 1'b1;
      errors++;
      return;
    end
    repeat (2) @(negedge clk);
    assert (dut_ready && !result_wr.we) else begin
      $display("FAILED @%0t: %s DUT left idle after the run", $time, name);
      errors++;
    end
    assert (total_writes == m * n) else begin
      $display("FAILED @%0t: %s %0d writes, expected %0d", $time, name, total_writes, m * n);
      errors++;
    end
    for (int idx = 0; idx < m * n; idx++) begin
      expected = golden_element(idx / n, idx % n, k);
      assert (write_count[idx] == 1) else begin
        $display("FAILED @%0t: %s addr %0d written %0d times", $time, name, idx,
                 write_count[idx]);
        errors++;
      end
      assert (result_mem[idx] == expected) else begin
        $display("FAILED @%0t: %s addr %0d expected %08h got %08h", $time, name, idx,
                 expected, result_mem[idx]);
        errors++;
      end
    end
    report_test(name, errs_before);
  endtask

  initial begin
    int errs_before;
    int r;
    seed           = 32'he1bc_27bb;
    reset_n        = 1'b0;
    dut_valid      = 1'b0;
    input_rd_data  = '0;
    weight_rd_data = '0;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    timed_out      = 1'b0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    errs_before = errors;
    repeat (3) begin
      @(negedge clk);
      assert (dut_ready === 1'b1 && result_wr.we === 1'b0) else begin
        $display("FAILED @%0t: reset_values ready %b we %b", $time, dut_ready, result_wr.we);
        errors++;
      end
    end
    report_test("reset_values", errs_before);

    run_case("single_element", 1, 1, 1, 1'b0, 1'b0);
    for (int i = 0; i < 10; i++) begin
      r = $random(seed);
      run_case($sformatf("random_shape_%0d", i), 1 + (r & 3), 1 + ((r >> 2) & 3),
               1 + ((r >> 4) & 3), 1'b0, 1'b0);
    end
    run_case("back_to_back_3x2x3", 3, 2, 3, 1'b0, 1'b0);
    run_case("back_to_back_1x4x1", 1, 4, 1, 1'b0, 1'b0);
    run_case("valid_held_busy", 2, 3, 2, 1'b1, 1'b0);
    run_case("wrap_around", 3, 4, 2, 1'b0, 1'b1);

    assert (u_matmul_top.u_sva.fail_count == 0) else begin
      $display("Concurrent assertions failed %0d times", u_matmul_top.u_sva.fail_count);
      errors++;
    end
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/matmul_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_sva
  import matmul_pkg::*;
(
  input logic     clk,
  input logic     reset_n,
  input logic     dut_valid,
  input logic     dut_ready,
  input sram_wr_t result_wr
);

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // Accepted start drops ready on the next cycle
  property ready_drops_after_start;
    @(posedge clk) disable iff (!reset_n)
      (dut_valid && dut_ready) |=> !dut_ready;
  endproperty

  // Writes only happen inside a run
  property no_write_while_ready;
    @(posedge clk) disable iff (!reset_n)
      $rose(result_wr.we) |-> !dut_ready;
  endproperty

  property single_cycle_write;
    @(posedge clk) disable iff (!reset_n)
      result_wr.we |=> !result_wr.we;
  endproperty

  a_ready_drops: assert property (ready_drops_after_start)
    else begin
      fail_count++;
      $error("dut_ready still high the cycle after an accepted start");
    end

  a_no_idle_write: assert property (no_write_while_ready)
    else begin
      fail_count++;
      $error("result write started while dut_ready was high");
    end

  a_write_pulse: assert property (single_cycle_write)
    else begin
      fail_count++;
      $error("result_wr.we high on two consecutive cycles");
    end

endmodule

`default_nettype wire

// ==== verilog/matmul_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_top
  import matmul_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,

  // Start handshake
  input  logic     dut_valid,
  output logic     dut_ready,

  // Input SRAM read port, matrix A
  output addr_t    input_rd_addr,
  input  data_t    input_rd_data,

  // Weight SRAM read port, matrix B
  output addr_t    weight_rd_addr,
  input  data_t    weight_rd_data,

  // Result SRAM write port, matrix C
  output sram_wr_t result_wr
);

  ctrl_cmd_t    cmd;
  ctrl_status_t status;
  data_t        acc;

  matmul_ctrl u_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .dut_valid (dut_valid),
    .status    (status),
    .cmd       (cmd),
    .dut_ready (dut_ready)
  );

  matmul_addr_gen u_addr_gen (
    .clk            (clk),
    .reset_n        (reset_n),
    .cmd            (cmd),
    .input_rd_data  (input_rd_data),
    .weight_rd_data (weight_rd_data),
    .input_rd_addr  (input_rd_addr),
    .weight_rd_addr (weight_rd_addr),
    .status         (status)
  );

  // Operands come straight from the SRAM read data
  matmul_mac u_mac (
    .clk     (clk),
    .reset_n (reset_n),
    .cmd     (cmd),
    .a       (input_rd_data),
    .b       (weight_rd_data),
    .acc     (acc)
  );

  matmul_result_writer u_result_writer (
    .clk       (clk),
    .reset_n   (reset_n),
    .cmd       (cmd),
    .acc       (acc),
    .result_wr (result_wr)
  );

endmodule

`default_nettype wire

// ==== verilog/matmul_result_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_result_writer
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  ctrl_cmd_t cmd,
  input  data_t     acc,
  output sram_wr_t  result_wr
);

  // Next C address, elements finish in row-major order
  addr_t wr_addr;

  always_ff @(posedge clk) begin
    if (!reset_n || cmd.rewind) begin
      wr_addr <= '0;
    end else if (cmd.write) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      result_wr <= '0;
    end else begin
      // Single-cycle write pulse
      result_wr.we <= cmd.write;
      if (cmd.write) begin
        result_wr.addr <= wr_addr;
        result_wr.data <= acc;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/matmul_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_mac
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  ctrl_cmd_t cmd,
  input  data_t     a,
  input  data_t     b,
  output data_t     acc
);

  data_t product;

  // Low word of the product, same for signed and unsigned operands
  assign product = a * b;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      acc <= '0;
    end else if (cmd.write || cmd.rewind) begin
      // Sum handed to the writer this cycle, next element starts at zero
      acc <= '0;
    end else if (cmd.acc_en) begin
      acc <= acc + product;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/matmul_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matmul_config.svh"

module matmul_addr_gen
  import matmul_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  input  ctrl_cmd_t    cmd,
  input  data_t        input_rd_data,
  input  data_t        weight_rd_data,
  output addr_t        input_rd_addr,
  output addr_t        weight_rd_addr,
  output ctrl_status_t status
);

  // Both matrices start right after their header word
  localparam addr_t first_addr = `MATMUL_ADDR_WIDTH'd1;

  header_u hdr_a;
  header_u hdr_b;

  // Captured dimensions
  dim_t m_dim;
  dim_t k_dim;
  dim_t n_dim;

  // Position of the current element and its k
  dim_t m_cnt;
  dim_t n_cnt;
  dim_t k_cnt;
  dim_t m_nxt;
  dim_t n_nxt;
  dim_t k_nxt;

  logic k_last;
  logic n_last;
  logic m_last;

  assign hdr_a.raw = input_rd_data;
  assign hdr_b.raw = weight_rd_data;

  assign k_last = (k_cnt == k_dim - 1'b1);
  assign n_last = (n_cnt == n_dim - 1'b1);
  assign m_last = (m_cnt == m_dim - 1'b1);

  assign status.elem_last   = k_last;
  assign status.matrix_last = m_last && n_last;

  // k innermost, then columns of C, then rows
  always_comb begin
    m_nxt = m_cnt;
    n_nxt = n_cnt;
    k_nxt = k_cnt + 1'b1;
    if (k_last) begin
      k_nxt = '0;
      if (n_last) begin
        n_nxt = '0;
        m_nxt = m_last ? '0 : m_cnt + 1'b1;
      end else begin
        n_nxt = n_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n || cmd.rewind) begin
      m_dim          <= '0;
      k_dim          <= '0;
      n_dim          <= '0;
      m_cnt          <= '0;
      n_cnt          <= '0;
      k_cnt          <= '0;
      input_rd_addr  <= '0;
      weight_rd_addr <= '0;
    end else begin
      if (cmd.load_dims) begin
        // B rows are taken to equal A cols
        m_dim          <= hdr_a.dims.rows;
        k_dim          <= hdr_a.dims.cols;
        n_dim          <= hdr_b.dims.cols;
        input_rd_addr  <= first_addr;
        weight_rd_addr <= first_addr;
      end
      if (cmd.step) begin
        m_cnt          <= m_nxt;
        n_cnt          <= n_nxt;
        k_cnt          <= k_nxt;
        // A row-major, B column by column
        input_rd_addr  <= first_addr + m_nxt * k_dim + k_nxt;
        weight_rd_addr <= first_addr + n_nxt * k_dim + k_nxt;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/matmul_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_ctrl
  import matmul_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  input  logic         dut_valid,
  input  ctrl_status_t status,
  output ctrl_cmd_t    cmd,
  output logic         dut_ready
);

  typedef enum logic [2:0] {
    IDLE,
    HEADER,
    LOAD,
    STREAM,
    DRAIN,
    WRITE,
    DONE
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   accept;
  logic   stream_d;
  logic   final_elem;

  // Start handshake, only seen while idle
  assign accept = dut_valid && dut_ready;

  always_comb begin
    state_nxt = state;
    cmd       = '0;
    case (state)
      IDLE: begin
        if (accept) begin
          // Point both reads at the header word
          cmd.rewind = 1'b1;
          state_nxt  = HEADER;
        end
      end
      HEADER: begin
        // Header read in flight
        state_nxt = LOAD;
      end
      LOAD: begin
        cmd.load_dims = 1'b1;
        state_nxt     = STREAM;
      end
      STREAM: begin
        // One k per cycle, last step moves to the next element
        cmd.step = 1'b1;
        if (status.elem_last) begin
          state_nxt = DRAIN;
        end
      end
      DRAIN: begin
        state_nxt = WRITE;
      end
      WRITE: begin
        cmd.write = 1'b1;
        state_nxt = final_elem ? DONE : STREAM;
      end
      DONE: begin
        state_nxt = IDLE;
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
    // Read data trails each streamed address by one cycle
    cmd.acc_en = stream_d;
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state      <= IDLE;
      dut_ready  <= 1'b1;
      stream_d   <= 1'b0;
      final_elem <= 1'b0;
    end else begin
      state     <= state_nxt;
      dut_ready <= (state_nxt == IDLE);
      stream_d  <= (state == STREAM);
      // Counters move past the element on its last step, so keep the flag here
      if (state == STREAM && status.elem_last) begin
        final_elem <= status.matrix_last;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/matmul_pkg.sv ====
`default_nettype none

`include "matmul_config.svh"

package matmul_pkg;

  typedef logic [`MATMUL_DATA_WIDTH-1:0] data_t;
  typedef logic [`MATMUL_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`MATMUL_DIM_WIDTH-1:0]  dim_t;

  // Header word layout, rows in the upper half
  typedef struct packed {
    dim_t rows;
    dim_t cols;
  } dims_t;

  // Word at address 0 seen either as raw data or as a dimension pair
  typedef union packed {
    dims_t dims;
    data_t raw;
  } header_u;

  // Per-cycle commands from the controller
  typedef struct packed {
    logic load_dims;
    logic rewind;
    logic step;
    logic acc_en;
    logic write;
  } ctrl_cmd_t;

  // Address generator flags back to the controller
  typedef struct packed {
    logic elem_last;
    logic matrix_last;
  } ctrl_status_t;

  // Result SRAM write port
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t data;
  } sram_wr_t;

endpackage

`default_nettype wire

// ==== verilog/matmul_config.svh ====
`ifndef MATMUL_CONFIG_SVH
`define MATMUL_CONFIG_SVH

// SRAM word, one signed matrix element
`define MATMUL_DATA_WIDTH 32

// SRAM address for all three arrays
`define MATMUL_ADDR_WIDTH 16

// One matrix dimension, half of a header word
`define MATMUL_DIM_WIDTH 16

`endif
